// ==== tests/ext_bridge_tests.txt ====
// columns: op, expected dout_en, host value, expected dout
// op 0 test, 1 open, 2 strobe, 3 strobe with reply unchecked, 4 close, 5 status, f end
0 0 0001 0000
1 0 0000 0000
2 1 0061 0000
2 1 0010 f080
2 1 0000 02fa
2 1 2222 0000
2 1 1111 0000
2 1 4444 0000
2 1 3333 0000
4 0 0000 0000
0 0 0002 0000
1 0 0000 0000
2 1 0062 0000
2 1 0010 0000
2 1 0000 0000
2 1 0000 2222
2 1 0000 1111
2 1 0000 4444
2 1 0000 3333
4 0 0000 0000
0 0 0003 0000
1 0 0000 0000
2 1 0061 0000
2 1 03fc f080
2 1 0000 02fa
2 1 beef 0000
2 1 dead 0000
2 1 0bad 0000
2 1 cafe 0000
4 0 0000 0000
1 0 0000 0000
2 1 0061 0000
2 1 0c10 f080
2 1 0000 02fa
2 1 3210 0000
2 1 7654 0000
4 0 0000 0000
1 0 0000 0000
2 1 0062 0000
2 1 03fc 0000
2 1 0000 0000
2 1 0000 beef
2 1 0000 dead
2 1 0000 0bad
2 1 0000 cafe
4 0 0000 0000
1 0 0000 0000
2 1 0062 0000
2 1 0c10 0000
2 1 0000 0000
2 1 0000 3210
2 1 0000 7654
4 0 0000 0000
0 0 0004 0000
1 0 0000 0000
2 1 0063 0000
5 1 0002 0000
5 1 0001 0000
4 0 0000 0000
0 0 0005 0000
1 0 0000 0000
2 0 0040 0000
2 0 0001 0000
4 0 0000 0000
1 0 0000 0000
2 1 0061 0000
2 1 0010 f080
2 1 0000 02fa
3 1 9999 0000
4 0 0000 0000
1 0 0000 0000
2 1 0062 0000
2 1 0010 0000
2 1 0000 0000
2 1 0000 2222
2 1 0000 1111
4 0 0000 0000
f 0 0000 0000

// ==== ext_bridge.f ====
+incdir+rtl
rtl/ext_bridge_pkg.sv
rtl/ext_cmd_port.sv
rtl/ext_wb_master.sv
rtl/wb_bank_fabric.sv
rtl/wb_ram_bank.sv
rtl/ext_bridge_top.sv
tests/ext_bridge_sva.sv
tests/ext_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the host bridge testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ext_bridge_tb \
	-f ext_bridge.f --Mdir obj_dir -o ext_bridge_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/ext_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== tests/ext_bridge_tb.sv ====
// Host bridge testbench
`timescale 1ns/100ps
`default_nettype none

module ext_bridge_tb;

	// the script buffer holds four columns per line
	localparam int MAX_WORDS = 1024;

	logic clk_sys;
	logic arst_n;
	ext_bridge_pkg::host_in_t host_i;
	ext_bridge_pkg::host_out_t host_o;
	logic [1:0] sys_req;
	logic [1:0] sys_status;

	logic [15:0] script [MAX_WORDS];
	int n_lines;
	integer seed;
	int errors;
	int checks;
	int tests_run;
	int tests_bad;
	// running count of cycles with sys_status high
	int pulse_cnt = 0;
	logic [1:0] last_status = 2'b00;

	ext_bridge_top dut (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.host_i(host_i),
		.host_o(host_o),
		.sys_req(sys_req),
		.sys_status(sys_status)
	);

	// handshake checks sit on the internal wishbone bus of the top level
	bind ext_bridge_top ext_bridge_sva u_sva (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.m_req(m_req),
		.m_rsp(m_rsp),
		.bank_req(bank_req),
		.io_wait(io_wait)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	// every high cycle counts, so a stretched pulse shows up as more than one
	always @(posedge clk_sys) begin
		if (sys_status != 2'b00) begin
			pulse_cnt <= pulse_cnt + 1;
			last_status <= sys_status;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_test(input int num, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %0d: ok", num);
		end else begin
			tests_bad++;
			$display("test %0d: %0d error(s)", num, errs);
		end
	endtask

	// lines up to the end marker, or none when the marker is missing
	function automatic int count_lines();
		int n;
		n = 0;
		while ((4 * n + 3 < MAX_WORDS) && (script[4 * n] !== 16'h000f)) begin
			n++;
		end
		if (4 * n + 3 >= MAX_WORDS) begin
			n = 0;
		end
		return n;
	endfunction

	initial begin
		logic [15:0] op;
		logic [15:0] en_exp;
		logic [15:0] value;
		logic [15:0] reply;
		int test_no;
		int test_err;
		int pulse_base;
		int gap;
		int status_cnt;

		seed = 1945;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_bad = 0;
		test_no = 0;
		test_err = 0;
		status_cnt = 0;
		host_i = '0;
		sys_req = '0;
		arst_n = 1'b0;
		$readmemh("tests/ext_bridge_tests.txt", script);
		n_lines = count_lines();
		wait_cycles(2);
		arst_n <= 1'b1;
		wait_cycles(2);
		for (int i = 0; i < n_lines; i++) begin
			op = script[4 * i];
			en_exp = script[4 * i + 1];
			value = script[4 * i + 2];
			reply = script[4 * i + 3];
			case (op)
				16'h0000: begin
					// a new test closes the previous one
					if (test_no != 0) begin
						report_test(test_no, errors - test_err);
					end
					test_no = int'(value);
					test_err = errors;
				end
				16'h0001: begin
					@(posedge clk_sys);
					host_i.enable <= 1'b1;
					wait_cycles(2);
				end
				16'h0002, 16'h0003, 16'h0005: begin
					@(posedge clk_sys);
					if (op == 16'h0005) begin
						sys_req <= 2'($random(seed));
						status_cnt++;
					end
					pulse_base = pulse_cnt;
					host_i.din <= value;
					host_i.strobe <= 1'b1;
					@(posedge clk_sys);
					host_i.strobe <= 1'b0;
					// the reply is read 7 cycles after the strobe edge
					wait_cycles(6);
					@(negedge clk_sys);
					if (op == 16'h0002) begin
						check_value("dout_en", 32'(host_o.dout_en), 32'(en_exp));
						check_value("dout", 32'(host_o.dout), 32'(reply));
					end else if (op == 16'h0005) begin
						check_value("dout_en", 32'(host_o.dout_en), 32'(en_exp));
						check_value("dout", 32'(host_o.dout), 32'(sys_req));
						check_value("sys_status pulse count", 32'(pulse_cnt - pulse_base), 32'd1);
						check_value("sys_status", 32'(last_status), 32'(value[1:0]));
					end
					gap = 8 + int'($unsigned($random(seed)) % 5);
					wait_cycles(gap - 8);
				end
				16'h0004: begin
					@(posedge clk_sys);
					host_i.enable <= 1'b0;
					host_i.din <= '0;
					wait_cycles(2);
					@(negedge clk_sys);
					check_value("dout_en", 32'(host_o.dout_en), 32'(en_exp));
					check_value("dout", 32'(host_o.dout), 32'(reply));
				end
				default: begin
					errors++;
					$display("script line %0d holds an unknown operation %h", i + 1, op);
				end
			endcase
		end
		if (test_no != 0) begin
			report_test(test_no, errors - test_err);
		end
		// stray pulses outside the status strobes show up in the total
		check_value("sys_status pulse total", 32'(pulse_cnt), 32'(status_cnt));
		if (n_lines == 0) begin
			errors++;
			$display("no test script lines could be read");
		end
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// no script line needs anywhere near 20 cycles
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 20) @(posedge clk_sys);
		$display("timeout: the script of %0d lines did not finish in %0d cycles",
			n_lines, n_lines * 20);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/ext_bridge_sva.sv ====
// Wishbone handshake assertions
`timescale 1ns/100ps
`default_nettype none
`include "ext_bridge_config.svh"

module ext_bridge_sva (
	input wire logic clk_sys,
	input wire logic arst_n,
	input ext_bridge_pkg::wb_req_t m_req,
	input ext_bridge_pkg::wb_rsp_t m_rsp,
	input ext_bridge_pkg::wb_req_t bank_req [`EXT_NUM_BANKS],
	input wire logic io_wait
);

	logic [`EXT_NUM_BANKS-1:0] bank_stb;

	// gather the per-bank strobes into one vector
	always_comb begin
		for (int k = 0; k < `EXT_NUM_BANKS; k++) begin
			bank_stb[k] = bank_req[k].stb;
		end
	end

	// a classic cycle keeps stb up until the slave acks
	a_stb_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
		m_req.stb && !m_rsp.ack |=> m_req.stb)
		else $error("stb dropped before ack");

	a_ack_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		m_rsp.ack |=> !m_rsp.ack)
		else $error("ack held for two cycles");

	// the fabric decode selects one bank at most
	a_one_bank: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$onehot0(bank_stb))
		else $error("more than one bank strobed");

	a_wait_after_ack: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(io_wait) |-> $past(m_rsp.ack))
		else $error("io_wait fell without an ack");

endmodule

`default_nettype wire

// ==== rtl/ext_bridge_top.sv ====
// Host bridge top level
`timescale 1ns/100ps
`default_nettype none
`include "ext_bridge_config.svh"

module ext_bridge_top (
	input wire logic clk_sys,
	input wire logic arst_n,
	input ext_bridge_pkg::host_in_t host_i,
	output ext_bridge_pkg::host_out_t host_o,
	input wire logic [1:0] sys_req,
	output logic [1:0] sys_status
);

	ext_bridge_pkg::ext_op_t op;
	logic io_wait;
	logic [31:0] rdata;
	ext_bridge_pkg::wb_req_t m_req;
	ext_bridge_pkg::wb_rsp_t m_rsp;
	ext_bridge_pkg::wb_req_t bank_req [`EXT_NUM_BANKS];
	ext_bridge_pkg::wb_rsp_t bank_rsp [`EXT_NUM_BANKS];

	// host side decodes commands into single word requests
	ext_cmd_port u_cmd_port (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.host_i(host_i),
		.host_o(host_o),
		.io_wait(io_wait),
		.rdata(rdata),
		.sys_req(sys_req),
		.sys_status(sys_status),
		.op(op)
	);

	// each request becomes one wishbone classic cycle
	ext_wb_master u_wb_master (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.op(op),
		.wb_o(m_req),
		.wb_i(m_rsp),
		.rdata(rdata),
		.io_wait(io_wait)
	);

	wb_bank_fabric u_fabric (
		.wb_i(m_req),
		.wb_o(m_rsp),
		.bank_req(bank_req),
		.bank_rsp(bank_rsp)
	);

	// identical banks sit behind the fabric
	for (genvar k = 0; k < `EXT_NUM_BANKS; k++) begin : g_bank
		wb_ram_bank u_bank (
			.clk_sys(clk_sys),
			.arst_n(arst_n),
			.wb_i(bank_req[k]),
			.wb_o(bank_rsp[k])
		);
	end

endmodule

`default_nettype wire

// ==== rtl/wb_ram_bank.sv ====
// Wishbone RAM bank
`timescale 1ns/100ps
`default_nettype none
`include "ext_bridge_config.svh"

module wb_ram_bank (
	input wire logic clk_sys,
	input wire logic arst_n,
	input ext_bridge_pkg::wb_req_t wb_i,
	output ext_bridge_pkg::wb_rsp_t wb_o
);

	localparam int WORD_BITS = $clog2(`EXT_BANK_WORDS);

	logic [31:0] mem [`EXT_BANK_WORDS];
	logic [WORD_BITS-1:0] adr_q;
	logic [31:0] dat_q;
	logic we_q;
	logic [31:0] rd_q;
	// set in the wait state between address capture and ack
	logic busy;
	logic ack_q;
	logic start;

	// a new access may only start once the previous ack has gone
	assign start = wb_i.cyc && wb_i.stb && !busy && !ack_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			busy <= start;
			// ack lasts one cycle and follows the wait state
			ack_q <= busy;
		end
	end

	// the first cycle takes the word address and the write data
	always_ff @(posedge clk_sys) begin
		if (start) begin
			adr_q <= wb_i.adr[WORD_BITS+1:2];
			dat_q <= wb_i.dat_w;
			we_q <= wb_i.we;
		end
	end

	// the second cycle does the RAM access
	always_ff @(posedge clk_sys) begin
		if (busy) begin
			if (we_q) begin
				mem[adr_q] <= dat_q;
			end
			rd_q <= mem[adr_q];
		end
	end

	assign wb_o.dat_r = rd_q;
	assign wb_o.ack = ack_q;

endmodule

`default_nettype wire

// ==== rtl/wb_bank_fabric.sv ====
// Wishbone bank fabric
`timescale 1ns/100ps
`default_nettype none
`include "ext_bridge_config.svh"

module wb_bank_fabric (
	input ext_bridge_pkg::wb_req_t wb_i,
	output ext_bridge_pkg::wb_rsp_t wb_o,
	output ext_bridge_pkg::wb_req_t bank_req [`EXT_NUM_BANKS],
	input ext_bridge_pkg::wb_rsp_t bank_rsp [`EXT_NUM_BANKS]
);

	localparam int WORD_BITS = $clog2(`EXT_BANK_WORDS);
	// a single bank still needs one bit of index
	localparam int BANK_BITS = (`EXT_NUM_BANKS > 1) ? $clog2(`EXT_NUM_BANKS) : 1;

	logic [BANK_BITS-1:0] bank_sel;

	// the bank index sits just above the word index
	// address bits above it are ignored and alias
	assign bank_sel = wb_i.adr[WORD_BITS+2 +: BANK_BITS];

	always_comb begin
		wb_o = '0;
		for (int k = 0; k < `EXT_NUM_BANKS; k++) begin
			// every bank sees the address and data
			bank_req[k] = wb_i;
			// only the decoded bank sees the cycle
			bank_req[k].cyc = wb_i.cyc && (bank_sel == BANK_BITS'(k));
			bank_req[k].stb = wb_i.stb && (bank_sel == BANK_BITS'(k));
			// the selected bank answers the master as it is
			if (bank_sel == BANK_BITS'(k)) begin
				wb_o = bank_rsp[k];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ext_wb_master.sv ====
// Wishbone classic master
`timescale 1ns/100ps
`default_nettype none

module ext_wb_master (
	input wire logic clk_sys,
	input wire logic arst_n,
	input ext_bridge_pkg::ext_op_t op,
	output ext_bridge_pkg::wb_req_t wb_o,
	input ext_bridge_pkg::wb_rsp_t wb_i,
	output logic [31:0] rdata,
	output logic io_wait
);

	typedef enum logic {
		ST_IDLE,
		ST_CYCLE
	} state_t;

	state_t state;
	logic [31:0] adr_q;
	logic [31:0] dat_q;
	logic we_q;

	// one cycle runs at a time and ends on the slave ack
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (op.rd || op.wr) begin
						state <= ST_CYCLE;
					end
				end
				ST_CYCLE: begin
					if (wb_i.ack) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request fields are taken from the op pulse and held for the whole cycle
	always_ff @(posedge clk_sys) begin
		if ((state == ST_IDLE) && (op.rd || op.wr)) begin
			adr_q <= op.addr;
			dat_q <= op.wdata;
			we_q <= op.wr;
		end
		if ((state == ST_CYCLE) && wb_i.ack && !we_q) begin
			rdata <= wb_i.dat_r;
		end
	end

	// cyc and stb rise together and stay up until the ack
	assign wb_o.adr = adr_q;
	assign wb_o.dat_w = dat_q;
	assign wb_o.sel = 4'hf;
	assign wb_o.we = we_q;
	assign wb_o.cyc = (state == ST_CYCLE);
	assign wb_o.stb = (state == ST_CYCLE);

	// io_wait frames the transfer from the cycle after the pulse to the cycle after ack
	assign io_wait = (state == ST_CYCLE);

endmodule

`default_nettype wire

// ==== rtl/ext_cmd_port.sv ====
// Host command port
`timescale 1ns/100ps
`default_nettype none
`include "ext_bridge_config.svh"

module ext_cmd_port (
	input wire logic clk_sys,
	input wire logic arst_n,
	input ext_bridge_pkg::host_in_t host_i,
	output ext_bridge_pkg::host_out_t host_o,
	input wire logic io_wait,
	input wire logic [31:0] rdata,
	input wire logic [1:0] sys_req,
	output logic [1:0] sys_status,
	output ext_bridge_pkg::ext_op_t op
);

	localparam logic [31:0] CLK_RATE = `EXT_CLK_RATE;

	// strobe count inside the open command, saturating at all ones
	logic [9:0] byte_cnt;
	logic [15:0] cmd;
	// selects the high half of a data word when set
	logic half_hi;
	logic old_wait;
	logic pending;
	logic [15:0] dout;
	logic dout_en;
	logic [31:0] op_addr;
	logic [31:0] op_wdata;
	logic op_rd;
	logic op_wr;

	logic cmd_stb;
	logic data_stb;
	logic body_stb;
	logic is_write;
	logic is_read;
	logic is_status;

	// the first strobe of a command carries the code and the rest carry values
	assign cmd_stb = host_i.enable && host_i.strobe && (byte_cnt == 10'd0);
	assign data_stb = host_i.enable && host_i.strobe && (byte_cnt != 10'd0);
	// strobes after the two address halves carry data
	assign body_stb = data_stb && (byte_cnt > 10'd2);

	assign is_write = (cmd == `EXT_CMD_WRITE);
	assign is_read = (cmd == `EXT_CMD_READ);
	assign is_status = (cmd == `EXT_CMD_STATUS);

	// control state of the sequencer
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt <= '0;
			half_hi <= 1'b0;
			old_wait <= 1'b0;
			pending <= 1'b0;
			dout <= '0;
			dout_en <= 1'b0;
			op_rd <= 1'b0;
			op_wr <= 1'b0;
			sys_status <= '0;
		end else begin
			op_rd <= 1'b0;
			op_wr <= 1'b0;
			sys_status <= '0;
			if (!host_i.enable) begin
				// a closed command drops the port back to idle
				byte_cnt <= '0;
				half_hi <= 1'b0;
				old_wait <= 1'b0;
				pending <= 1'b0;
				dout <= '0;
				dout_en <= 1'b0;
			end else begin
				old_wait <= io_wait;
				if (host_i.strobe) begin
					// plain data strobes answer with zero
					dout <= '0;
					if (~&byte_cnt) begin
						byte_cnt <= byte_cnt + 10'd1;
					end
					if (byte_cnt == 10'd0) begin
						half_hi <= 1'b0;
						dout_en <= (host_i.din >= `EXT_CMD_WRITE) &&
							(host_i.din <= `EXT_CMD_STATUS);
					end else if (is_write) begin
						// the host reads the clock rate back while sending the address
						if (byte_cnt == 10'd1) begin
							dout <= CLK_RATE[15:0];
						end else if (byte_cnt == 10'd2) begin
							dout <= CLK_RATE[31:16];
						end else begin
							// the write goes out once the high half is in
							if (half_hi) begin
								op_wr <= 1'b1;
							end
							half_hi <= ~half_hi;
						end
					end else if (is_read) begin
						if (byte_cnt > 10'd2) begin
							if (!half_hi) begin
								op_rd <= 1'b1;
								pending <= 1'b1;
							end else begin
								dout <= rdata[31:16];
							end
							half_hi <= ~half_hi;
						end
					end else if (is_status) begin
						dout <= {14'd0, sys_req};
						sys_status <= host_i.din[1:0];
					end
				end
				// the low half of a read is ready once io_wait falls
				if (old_wait && !io_wait && pending) begin
					pending <= 1'b0;
					dout <= rdata[15:0];
				end
			end
		end
	end

	// command word, address and write data
	always_ff @(posedge clk_sys) begin
		if (cmd_stb) begin
			cmd <= host_i.din;
		end
		if ((is_write || is_read) && data_stb && (byte_cnt == 10'd1)) begin
			op_addr[15:0] <= host_i.din;
		end
		if ((is_write || is_read) && data_stb && (byte_cnt == 10'd2)) begin
			op_addr[31:16] <= host_i.din;
		end
		if (is_write && body_stb) begin
			if (!half_hi) begin
				// step to the next word before every data word but the first
				if (byte_cnt > 10'd4) begin
					op_addr <= op_addr + 32'd4;
				end
				op_wdata[15:0] <= host_i.din;
			end else begin
				op_wdata[31:16] <= host_i.din;
			end
		end
		// a read steps on after its high half has gone out
		if (is_read && body_stb && half_hi) begin
			op_addr <= op_addr + 32'd4;
		end
	end

	assign op.addr = op_addr;
	assign op.wdata = op_wdata;
	assign op.rd = op_rd;
	assign op.wr = op_wr;

	assign host_o.dout = dout;
	assign host_o.dout_en = dout_en;

endmodule

`default_nettype wire

// ==== rtl/ext_bridge_pkg.sv ====
// Host bridge types
`default_nettype none

package ext_bridge_pkg;

	// everything the host drives into the bridge
	typedef struct packed {
		// 16-bit command or data value
		logic [15:0] din;
		// one-cycle strobe per transfer
		logic strobe;
		// stays high while a command is open
		logic enable;
	} host_in_t;

	// everything the bridge returns to the host
	typedef struct packed {
		logic [15:0] dout;
		// high while the open command is one the bridge answers
		logic dout_en;
	} host_out_t;

	// wishbone classic request from master towards slave
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat_w;
		logic [3:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// wishbone classic response from slave back to master
	typedef struct packed {
		logic [31:0] dat_r;
		logic ack;
	} wb_rsp_t;

	// one request from the command port to the wishbone master
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic rd;
		logic wr;
	} ext_op_t;

endpackage

`default_nettype wire

// ==== rtl/ext_bridge_config.svh ====
// Host bridge configuration
`ifndef EXT_BRIDGE_CONFIG_SVH
`define EXT_BRIDGE_CONFIG_SVH

// system clock rate handed back to the host during write address strobes
`define EXT_CLK_RATE 32'd50000000

// memory layout as banks of 32-bit words
`define EXT_NUM_BANKS 4
// both counts are expected to be powers of two
`define EXT_BANK_WORDS 256

// host command codes carried by the first strobe of a command
`define EXT_CMD_WRITE 16'h0061
`define EXT_CMD_READ 16'h0062
`define EXT_CMD_STATUS 16'h0063

`endif
